//--- hdl/adcPkg.sv
package adcPkg;

    localparam int SAMPLE_WIDTH = 16;                   // bits per adc conversion
    localparam int NUM_AXES = 4;                        // adcs per set
    localparam int WORD_WIDTH = 32;                     // pot:cur packed word
    localparam int SEQ_WIDTH = 8;                       // frame counter width
    localparam int ADDR_WIDTH = 8;                      // axi4-lite byte address

    localparam int SCLK_HALF = 2;                       // clk cycles per sclk half period
    localparam int CONV_CYCLES = 8;                     // conv high time
    localparam int FRAME_CYCLES = CONV_CYCLES + SAMPLE_WIDTH * 2 * SCLK_HALF; // 72

    localparam int TIMER_WIDTH = $clog2(CONV_CYCLES);   // also covers SCLK_HALF
    localparam int BIT_CNT_WIDTH = $clog2(SAMPLE_WIDTH);
    localparam int AXIS_IDX_WIDTH = $clog2(NUM_AXES);

    localparam logic [ADDR_WIDTH-1:0] STATUS_ADDR = 8'h00;    // [15:8] pot seq, [7:0] cur seq
    localparam logic [ADDR_WIDTH-1:0] CONTROL_ADDR = 8'h04;   // [0] hold
    localparam logic [ADDR_WIDTH-1:0] AXIS_BASE_ADDR = 8'h10; // axis n at base + 4n
    localparam logic [ADDR_WIDTH-1:0] AXIS_END_ADDR = AXIS_BASE_ADDR + 8'(4 * NUM_AXES);

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // serial frame sequencer states
    typedef enum logic [1:0] {
        ADC_CONV,       // conv high, adc sampling
        ADC_SHIFT,      // clocking out 16 bits
        ADC_DONE        // last sclk high half, results published
    } adcState;

    // decoded register class for host access
    typedef enum logic [1:0] {
        REG_STATUS,
        REG_CONTROL,
        REG_AXIS,
        REG_NONE        // unmapped or misaligned
    } regSel;

endpackage

//--- hdl/feedbackIf.sv
interface feedbackIf;
    import adcPkg::*;

    logic [NUM_AXES-1:0][WORD_WIDTH-1:0] axisWord; // {pot, cur} per axis
    logic [SEQ_WIDTH-1:0] curSeq;                  // latched current frames
    logic [SEQ_WIDTH-1:0] potSeq;                  // latched pot frames
    logic hold;                                    // freeze latched samples

    modport source (
        output axisWord,
        output curSeq,
        output potSeq,
        input  hold
    );

    modport sink (
        input  axisWord,
        input  curSeq,
        input  potSeq,
        output hold
    );

endinterface

//--- hdl/Ltc1864x4.sv
module Ltc1864x4 (
    input  logic clk,
    input  logic arstN,
    output logic sclk,                                  // shared serial clock
    output logic conv,                                  // shared conversion strobe
    input  logic [adcPkg::NUM_AXES-1:0] miso,           // one data line per adc
    output logic [adcPkg::NUM_AXES-1:0][adcPkg::SAMPLE_WIDTH-1:0] out,
    output logic outReady                               // one cycle per frame
);
    import adcPkg::*;

    adcState state;
    logic [TIMER_WIDTH-1:0] cnt;                        // conv time / sclk half period
    logic [BIT_CNT_WIDTH-1:0] bitCnt;                   // bits shifted this frame
    logic [NUM_AXES-1:0][SAMPLE_WIDTH-1:0] shiftReg;
    logic halfDone;
    logic riseNow;
    logic latchNow;

    assign halfDone = (cnt == TIMER_WIDTH'(SCLK_HALF - 1));
    assign riseNow = (state == ADC_SHIFT) && !sclk && halfDone; // sclk about to go high
    assign latchNow = (state == ADC_DONE) && sclk && (cnt == '0); // sclk low only after reset

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= ADC_DONE;                          // so first edge starts a conv
            cnt <= TIMER_WIDTH'(SCLK_HALF - 1);
            bitCnt <= '0;
            sclk <= 1'b0;
            conv <= 1'b0;
            outReady <= 1'b0;
        end else begin
            outReady <= latchNow;
            case (state)
                ADC_CONV: begin
                    if (cnt == TIMER_WIDTH'(CONV_CYCLES - 1)) begin
                        conv <= 1'b0;
                        cnt <= '0;
                        bitCnt <= '0;
                        state <= ADC_SHIFT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ADC_SHIFT: begin
                    if (!halfDone) begin
                        cnt <= cnt + 1'b1;
                    end else begin
                        cnt <= '0;
                        sclk <= !sclk;
                        if (sclk) begin
                            bitCnt <= bitCnt + 1'b1;    // falling edge closes a bit
                        end else if (bitCnt == BIT_CNT_WIDTH'(SAMPLE_WIDTH - 1)) begin
                            state <= ADC_DONE;          // 16th rise keeps sclk high
                        end
                    end
                end
                ADC_DONE: begin
                    if (halfDone) begin
                        sclk <= 1'b0;
                        conv <= 1'b1;                   // next frame right away
                        cnt <= '0;
                        state <= ADC_CONV;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= ADC_DONE;
            endcase
        end
    end

    // samples shift in msb first
    always_ff @(posedge clk) begin
        if (riseNow) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                shiftReg[i] <= {shiftReg[i][SAMPLE_WIDTH-2:0], miso[i]};
            end
        end
        if (latchNow) begin
            out <= shiftReg;                            // all four channels at once
        end
    end

endmodule

//--- hdl/CtrlAdc.sv
module CtrlAdc (
    input  logic clk,
    input  logic arstN,
    output logic [1:0] sclk,                            // [1] pot set, [0] current set
    output logic [1:0] conv,                            // same order as sclk
    input  logic [2*adcPkg::NUM_AXES-1:0] miso,         // pot lines high, current lines low
    feedbackIf.source fb
);
    import adcPkg::*;

    logic [NUM_AXES-1:0][SAMPLE_WIDTH-1:0] potVal;      // live adc outputs
    logic [NUM_AXES-1:0][SAMPLE_WIDTH-1:0] curVal;
    logic [NUM_AXES-1:0][SAMPLE_WIDTH-1:0] potReg;      // host-visible copies
    logic [NUM_AXES-1:0][SAMPLE_WIDTH-1:0] curReg;
    logic potReady;
    logic curReady;

    // pot position set
    Ltc1864x4 adcPot (
        .clk      (clk),
        .arstN    (arstN),
        .sclk     (sclk[1]),
        .conv     (conv[1]),
        .miso     (miso[2*NUM_AXES-1:NUM_AXES]),
        .out      (potVal),
        .outReady (potReady)
    );

    // motor current set
    Ltc1864x4 adcCur (
        .clk      (clk),
        .arstN    (arstN),
        .sclk     (sclk[0]),
        .conv     (conv[0]),
        .miso     (miso[NUM_AXES-1:0]),
        .out      (curVal),
        .outReady (curReady)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            potReg <= '0;                               // reads 0 until first frame
            fb.potSeq <= '0;
        end else if (potReady && !fb.hold) begin
            potReg <= potVal;
            fb.potSeq <= fb.potSeq + 1'b1;              // wraps at 256
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            curReg <= '0;
            fb.curSeq <= '0;
        end else if (curReady && !fb.hold) begin
            curReg <= curVal;
            fb.curSeq <= fb.curSeq + 1'b1;
        end
    end

    // pot in upper half, current in lower half
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            fb.axisWord[i] = {potReg[i], curReg[i]};
        end
    end

endmodule

//--- hdl/AdcRegs.sv
module AdcRegs (
    input  logic clk,
    input  logic arstN,
    // write address
    input  logic awvalid,
    output logic awready,
    input  logic [adcPkg::ADDR_WIDTH-1:0] awaddr,
    // write data
    input  logic wvalid,
    output logic wready,
    input  logic [adcPkg::WORD_WIDTH-1:0] wdata,
    input  logic [adcPkg::WORD_WIDTH/8-1:0] wstrb,
    // write response
    output logic bvalid,
    input  logic bready,
    output logic [1:0] bresp,
    // read address
    input  logic arvalid,
    output logic arready,
    input  logic [adcPkg::ADDR_WIDTH-1:0] araddr,
    // read data
    output logic rvalid,
    input  logic rready,
    output logic [adcPkg::WORD_WIDTH-1:0] rdata,
    output logic [1:0] rresp,
    feedbackIf.sink fb
);
    import adcPkg::*;

    regSel rdSel;
    regSel wrSel;
    logic [AXIS_IDX_WIDTH-1:0] rdIdx;
    logic [WORD_WIDTH-1:0] rdWord;
    logic rdAccept;
    logic wrStart;
    logic wrAccept;

    function automatic regSel decodeSel(input logic [ADDR_WIDTH-1:0] addr);
        if (addr[1:0] != 2'b00) begin
            return REG_NONE;                            // word access only
        end else if (addr == STATUS_ADDR) begin
            return REG_STATUS;
        end else if (addr == CONTROL_ADDR) begin
            return REG_CONTROL;
        end else if (addr >= AXIS_BASE_ADDR && addr < AXIS_END_ADDR) begin
            return REG_AXIS;
        end
        return REG_NONE;
    endfunction

    assign rdSel = decodeSel(araddr);
    assign wrSel = decodeSel(awaddr);
    assign rdIdx = AXIS_IDX_WIDTH'((araddr - AXIS_BASE_ADDR) >> 2);

    // read mux
    always_comb begin
        case (rdSel)
            REG_STATUS:  rdWord = {{(WORD_WIDTH - 2 * SEQ_WIDTH){1'b0}}, fb.potSeq, fb.curSeq};
            REG_CONTROL: rdWord = {{(WORD_WIDTH - 1){1'b0}}, fb.hold};
            REG_AXIS:    rdWord = fb.axisWord[rdIdx];
            default:     rdWord = '0;                   // unmapped reads 0
        endcase
    end

    assign arready = !rvalid;                           // one read in flight
    assign rdAccept = arvalid && arready;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rvalid <= 1'b0;
        end else if (rdAccept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdata <= rdWord;                            // held until rready
            rresp <= (rdSel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // aw and w accepted together with a single cycle ready
    assign wrStart = awvalid && wvalid && !bvalid && !awready;
    assign wrAccept = awvalid && awready && wvalid && wready;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            fb.hold <= 1'b0;
        end else begin
            awready <= wrStart;
            wready <= wrStart;
            if (wrAccept) begin
                bvalid <= 1'b1;
                if (wrSel == REG_CONTROL && wstrb[0]) begin
                    fb.hold <= wdata[0];                // visible next cycle
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrAccept) begin
            bresp <= (wrSel == REG_CONTROL) ? RESP_OKAY : RESP_SLVERR; // status, axis read-only
        end
    end

endmodule

//--- hdl/AdcTop.sv
module AdcTop (
    input  logic clk,
    input  logic arstN,
    // pot adc set
    output logic sclkPot,
    output logic convPot,
    input  logic [adcPkg::NUM_AXES-1:0] misoPot,
    // current adc set
    output logic sclkCur,
    output logic convCur,
    input  logic [adcPkg::NUM_AXES-1:0] misoCur,
    // axi4-lite slave
    input  logic awvalid,
    output logic awready,
    input  logic [adcPkg::ADDR_WIDTH-1:0] awaddr,
    input  logic wvalid,
    output logic wready,
    input  logic [adcPkg::WORD_WIDTH-1:0] wdata,
    input  logic [adcPkg::WORD_WIDTH/8-1:0] wstrb,
    output logic bvalid,
    input  logic bready,
    output logic [1:0] bresp,
    input  logic arvalid,
    output logic arready,
    input  logic [adcPkg::ADDR_WIDTH-1:0] araddr,
    output logic rvalid,
    input  logic rready,
    output logic [adcPkg::WORD_WIDTH-1:0] rdata,
    output logic [1:0] rresp
);

    logic [1:0] sclk;                                   // {pot, cur}
    logic [1:0] conv;

    feedbackIf fbBus ();

    assign {sclkPot, sclkCur} = sclk;
    assign {convPot, convCur} = conv;

    CtrlAdc ctrlAdc (
        .clk   (clk),
        .arstN (arstN),
        .sclk  (sclk),
        .conv  (conv),
        .miso  ({misoPot, misoCur}),                    // pot lines in upper bits
        .fb    (fbBus.source)
    );

    AdcRegs adcRegs (
        .clk     (clk),
        .arstN   (arstN),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .fb      (fbBus.sink)
    );

endmodule

//--- testbench/adcTop_assertions.sv
module adcTopAssertions (
    input logic clk,
    input logic arstN,
    input logic sclkPot, convPot, sclkCur, convCur,
    input logic awready, wready, bvalid, bready, arready, rvalid, rready,
    input logic [adcPkg::WORD_WIDTH-1:0] rdata,
    input logic [1:0] rresp
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;                                 // failed assertions so far

    potStrobes: assert property (@(posedge clk) disable iff (!arstN) !(convPot && sclkPot))
        else begin
            failCount++;
            $error("pot set conv and sclk high together");
        end

    curStrobes: assert property (@(posedge clk) disable iff (!arstN) !(convCur && sclkCur))
        else begin
            failCount++;
            $error("current set conv and sclk high together");
        end

    // read data frozen under back-pressure
    readHold: assert property (@(posedge clk) disable iff (!arstN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            failCount++;
            $error("read channel changed before rready");
        end

    writeRespHold: assert property (@(posedge clk) disable iff (!arstN)
        bvalid && !bready |=> bvalid)
        else begin
            failCount++;
            $error("bvalid dropped before bready");
        end

    // first edge out of reset still shows reset values
    resetState: assert property (@(posedge clk) $rose(arstN) |->
        !convPot && !sclkPot && !convCur && !sclkCur && !rvalid && !bvalid
        && !awready && !wready && arready)
        else begin
            failCount++;
            $error("outputs not in reset state after reset");
        end

endmodule

bind AdcTop adcTopAssertions assertMon (.*);

//--- testbench/adcChecker.sv
module adcChecker (
    input  logic clk,
    input  logic arstN,
    input  logic sclkPot, convPot, sclkCur, convCur,
    input  logic [adcPkg::NUM_AXES-1:0] misoPot, misoCur,
    input  logic awvalid, awready, wvalid, wready, bvalid, bready,
    input  logic arvalid, arready, rvalid, rready,
    input  logic [adcPkg::ADDR_WIDTH-1:0] awaddr, araddr,
    input  logic [adcPkg::WORD_WIDTH-1:0] wdata, rdata,
    input  logic [3:0] wstrb,
    input  logic [1:0] bresp, rresp,
    output int errCount,
    output int checkCount
);
    timeunit 1ns;
    timeprecision 1ps;
    import adcPkg::*;

    logic [NUM_AXES-1:0][SAMPLE_WIDTH-1:0] potShift, curShift;   // bits of the running frame
    logic [NUM_AXES-1:0][SAMPLE_WIDTH-1:0] potLast, curLast;     // last frame taken while not held
    logic [SEQ_WIDTH-1:0] potCount, curCount;
    int potBits, curBits;
    logic holdShadow;                                  // control bit as written by the host
    logic [WORD_WIDTH-1:0] expData;
    logic [1:0] expResp, expBresp;
    logic [ADDR_WIDTH-1:0] rdAddr, wrAddr;

    // expected {resp, data} of a read at addr
    function automatic logic [WORD_WIDTH+1:0] refRead(input logic [ADDR_WIDTH-1:0] addr);
        if (addr == STATUS_ADDR) begin
            return {RESP_OKAY, 16'h0, potCount, curCount};
        end
        if (addr == CONTROL_ADDR) begin
            return {RESP_OKAY, 31'h0, holdShadow};
        end
        for (int n = 0; n < NUM_AXES; n++) begin
            if (addr == AXIS_BASE_ADDR + 8'(4 * n)) begin
                return {RESP_OKAY, potLast[n], curLast[n]}; // pot high, current low
            end
        end
        return {RESP_SLVERR, 32'h0};                   // unmapped or misaligned
    endfunction

    // bits enter msb first at sclk rise until conv comes back
    always @(posedge sclkPot or posedge convPot or negedge arstN) begin
        if (!arstN) begin
            potBits <= 0;
            potCount <= '0;
            potLast <= '0;
        end else if (convPot) begin
            if (potBits == SAMPLE_WIDTH && !holdShadow) begin
                potLast <= potShift;
                potCount <= potCount + 1'b1;           // wraps at 256
            end
            potBits <= 0;
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                potShift[i] <= {potShift[i][SAMPLE_WIDTH-2:0], misoPot[i]};
            end
            potBits <= potBits + 1;
        end
    end

    always @(posedge sclkCur or posedge convCur or negedge arstN) begin
        if (!arstN) begin
            curBits <= 0;
            curCount <= '0;
            curLast <= '0;
        end else if (convCur) begin
            if (curBits == SAMPLE_WIDTH && !holdShadow) begin
                curLast <= curShift;
                curCount <= curCount + 1'b1;
            end
            curBits <= 0;
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                curShift[i] <= {curShift[i][SAMPLE_WIDTH-2:0], misoCur[i]};
            end
            curBits <= curBits + 1;
        end
    end

    always @(posedge clk or negedge arstN) begin : compare
        int bad;
        if (!arstN) begin
            holdShadow <= 1'b0;
            errCount <= 0;
            checkCount <= 0;
        end else begin
            bad = 0;
            if (awvalid && awready && wvalid && wready) begin
                wrAddr <= awaddr;
                expBresp <= (awaddr == CONTROL_ADDR) ? RESP_OKAY : RESP_SLVERR; // rest read-only
                if (awaddr == CONTROL_ADDR && wstrb[0]) begin
                    holdShadow <= wdata[0];
                end
            end
            if (arvalid && arready) begin
                rdAddr <= araddr;
                {expResp, expData} <= refRead(araddr); // state as seen at the handshake
            end
            if (rvalid && rready) begin
                if (rdata !== expData || rresp !== expResp) begin
                    $display("ERR %0t: read 0x%02h gave %h resp %0d, expected %h resp %0d",
                             $time, rdAddr, rdata, rresp, expData, expResp);
                    bad++;
                end
            end
            if (bvalid && bready && bresp !== expBresp) begin
                $display("ERR %0t: write 0x%02h resp %0d, expected %0d",
                         $time, wrAddr, bresp, expBresp);
                bad++;
            end
            checkCount <= checkCount + int'(rvalid && rready) + int'(bvalid && bready);
            errCount <= errCount + bad;
        end
    end

endmodule

//--- testbench/tbAdc.sv
module serialAdcModel (
    input  logic clk,
    input  logic sclk,
    input  logic conv,
    input  logic [adcPkg::NUM_AXES-1:0][adcPkg::SAMPLE_WIDTH-1:0] sample,
    output logic [adcPkg::NUM_AXES-1:0] miso
);
    timeunit 1ns;
    timeprecision 1ps;
    import adcPkg::*;

    logic [NUM_AXES-1:0][SAMPLE_WIDTH-1:0] shiftOut;   // one set of four adcs
    logic sclkQ;                                       // sclk one edge back

    initial miso = '0;

    always @(posedge clk) begin                        // bits move the cycle after each sclk fall
        sclkQ <= sclk;
        if (conv) begin
            shiftOut <= sample;                        // new value only taken during conv
            for (int i = 0; i < NUM_AXES; i++) begin
                miso[i] <= sample[i][SAMPLE_WIDTH-1];  // msb ready before first rise
            end
        end else if (sclkQ && !sclk) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                shiftOut[i] <= shiftOut[i] << 1;
                miso[i] <= shiftOut[i][SAMPLE_WIDTH-2];
            end
        end
    end

endmodule

module tbAdc;
    timeunit 1ns;
    timeprecision 1ps;
    import adcPkg::*;

    localparam int MAX_CYCLES = 20000;                 // ~40 frames of FRAME_CYCLES is < 3000

    logic clk, arstN;
    logic sclkPot, convPot, sclkCur, convCur;
    logic [NUM_AXES-1:0] misoPot, misoCur;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [ADDR_WIDTH-1:0] awaddr, araddr;
    logic [WORD_WIDTH-1:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic [NUM_AXES-1:0][SAMPLE_WIDTH-1:0] potSample, curSample;
    int errCount, checkCount, cycles;

    AdcTop i_dut (.*);
    adcChecker monitor (.*);
    serialAdcModel potAdc (.clk(clk), .sclk(sclkPot), .conv(convPot), .sample(potSample),
                           .miso(misoPot));
    serialAdcModel curAdc (.clk(clk), .sclk(sclkCur), .conv(convCur), .sample(curSample),
                           .miso(misoCur));

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test sequence did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // returns at the first cycle of the next shift phase
    task automatic nextShift();
        do @(posedge clk); while (!convPot);
        do @(posedge clk); while (convPot);
    endtask

    task automatic newSamples();
        do @(posedge clk); while (convPot);
        do @(posedge clk); while (!convPot);
        for (int i = 0; i < NUM_AXES; i++) begin
            potSample[i] <= 16'($urandom);
            curSample[i] <= 16'($urandom);
        end
    endtask

    // stall = cycles of bready low after the write handshake
    task automatic writeReg(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [WORD_WIDTH-1:0] data,
                            input int stall);
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr <= addr;
        wvalid <= 1'b1;
        wdata <= data;
        bready <= (stall == 0);
        do @(posedge clk); while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        repeat (stall) @(posedge clk);
        bready <= 1'b1;
        do @(posedge clk); while (!bvalid);
    endtask

    // stall = cycles of rready low after the address handshake
    task automatic readReg(input logic [ADDR_WIDTH-1:0] addr, input int stall);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr <= addr;
        rready <= (stall == 0);
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        repeat (stall) @(posedge clk);
        rready <= 1'b1;
        do @(posedge clk); while (!rvalid);
        rready <= 1'b0;
    endtask

    task automatic readAxes(input bit slow);
        for (int n = 0; n < NUM_AXES; n++) begin
            readReg(AXIS_BASE_ADDR + 8'(4 * n), slow ? int'($urandom_range(6, 1)) : 0);
        end
        readReg(STATUS_ADDR, 0);
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b1;
        {awvalid, wvalid, arvalid, rready} = '0;
        bready = 1'b1;
        {awaddr, araddr, wdata, wstrb} = '0;
        potSample = '0;
        curSample = '0;
        cycles = 0;
        void'($urandom(11));
        arstN <= 1'b0;                                 // clean falling edge at time 0
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        wstrb <= 4'hF;
        readReg(CONTROL_ADDR, 0);                      // all zero before the first frame
        readAxes(1'b0);
        repeat (4) begin
            newSamples();
            nextShift();
            nextShift();
            readAxes(1'b1);
        end
        nextShift();
        writeReg(CONTROL_ADDR, 32'h1, 2);              // freeze
        readReg(CONTROL_ADDR, 0);
        readAxes(1'b0);
        newSamples();
        nextShift();
        nextShift();
        readAxes(1'b1);
        nextShift();
        readAxes(1'b0);
        writeReg(CONTROL_ADDR, 32'h0, 0);
        readReg(CONTROL_ADDR, 0);
        nextShift();
        nextShift();
        readAxes(1'b0);
        nextShift();
        readReg(8'h08, 0);
        readReg(8'h0C, 0);
        readReg(8'h20, 0);
        readReg(8'h12, 1);                             // misaligned inside the axis range
        writeReg(AXIS_BASE_ADDR + 8'h4, 32'hDEADBEEF, 3);
        writeReg(STATUS_ADDR, 32'h0000_00FF, 1);
        readAxes(1'b0);
        repeat (4) @(posedge clk);
        $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checkCount, errCount, i_dut.assertMon.failCount);
        if (errCount == 0 && i_dut.assertMon.failCount == 0 && checkCount > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/adcPkg.sv
hdl/feedbackIf.sv
hdl/Ltc1864x4.sv
hdl/CtrlAdc.sv
hdl/AdcRegs.sv
hdl/AdcTop.sv
testbench/adcTop_assertions.sv
testbench/adcChecker.sv
testbench/tbAdc.sv

//--- runSim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbAdc -f verilog.f -o simAdc > build.log 2>&1 \
    && ./obj_dir/simAdc +verilator+error+limit+100 > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; } || echo "simulation passed"
